/* tb/rv_core_patterns.txt */
// columns: instruction, write enable, destination register, expected result
// one instruction per line, pc starts at 0 and steps by 4
FFB00093 1 01 FFFFFFFB // addi x1, x0, -5
12300113 1 02 00000123 // addi x2, x0, 0x123
FFF0A193 1 03 00000001 // slti x3, x1, -1
FFF13213 1 04 00000001 // sltiu x4, x2, -1
0FF0C293 1 05 FFFFFF04 // xori x5, x1, 0xff
70016313 1 06 00000723 // ori x6, x2, 0x700
0F00F393 1 07 000000F0 // andi x7, x1, 0xf0
00411413 1 08 00001230 // slli x8, x2, 4
0040D493 1 09 0FFFFFFF // srli x9, x1, 4
4040D513 1 0A FFFFFFFF // srai x10, x1, 4
123455B7 1 0B 12345000 // lui x11, 0x12345
00001617 1 0C 0000102C // auipc x12, 1 at pc 0x2c
002086B3 1 0D 0000011E // add x13, x1, x2
40208733 1 0E FFFFFED8 // sub x14, x1, x2
0020A833 1 10 00000001 // slt x16, x1, x2
0020B8B3 1 11 00000000 // sltu x17, x1, x2
0040D9B3 1 13 7FFFFFFD // srl x19, x1, x4
4040DA33 1 14 FFFFFFFD // sra x20, x1, x4
0060FB33 1 16 00000723 // and x22, x1, x6
00510013 1 00 00000128 // addi x0, x2, 5
00200BB3 1 17 00000123 // add x23, x0, x2
00202023 0 00 00000000 // sw, unsupported
00000C17 1 18 00000058 // auipc x24, 0 at pc 0x58

/* sources.f */
verilog/rv_pkg.sv
verilog/rv_dec_if.sv
verilog/rv_imm_gen.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_fetch.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_rv_core -o sim_tb_rv_core

sim_out=$(./obj_dir/sim_tb_rv_core)
echo "$sim_out"

if grep -q "Simulation PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* tb/tb_rv_core.sv */
module tb_rv_core import rv_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int NUM_PAT        = 23;
    localparam int RETIRE_TIMEOUT = 40;

    logic      clk;
    logic      rst_n;
    word_t     inst;
    logic      inst_valid;
    word_t     inst_addr;
    logic      retire;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    // four words per pattern: instruction, write enable, destination, result
    word_t  pat_mem [0:NUM_PAT*4-1];
    integer seed;
    int     err_cnt;
    int     timeout_cnt;
    int     accepted;

    rv_core #(
        .RESET_PC (32'h0000_0000)
    ) i_rv_core (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .inst_addr_o  (inst_addr),
        .retire_o     (retire),
        .wb_en_o      (wb_en),
        .wb_addr_o    (wb_addr),
        .wb_data_o    (wb_data)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // valid low for one cycle, junk on the bus must not retire
    task automatic stall_cycle();
        @(negedge clk);
        inst_valid = 1'b0;
        inst       = $random(seed);
        #(CLK_PERIOD/4);
        check_bit("retire_o", retire, 1'b0);
        check_bit("wb_en_o", wb_en, 1'b0);
        // pc only moves on accepted words
        check_word("inst_addr_o", inst_addr, word_t'(4 * accepted));
    endtask

    // present one pattern, check before the accepting edge
    task automatic run_pattern(input int idx);
        int   wait_cnt;
        logic exp_en;
        wait_cnt = 0;
        exp_en   = pat_mem[idx*4+1][0];
        @(negedge clk);
        inst       = pat_mem[idx*4];
        inst_valid = 1'b1;
        do begin
            #1;
            wait_cnt++;
        end while (retire !== 1'b1 && wait_cnt < RETIRE_TIMEOUT);
        if (retire !== 1'b1) begin
            $display("timeout: retire_o did not rise for pattern %0d", idx);
            timeout_cnt++;
        end else begin
            check_word("inst_addr_o", inst_addr, word_t'(4 * accepted));
            check_bit("wb_en_o", wb_en, exp_en);
            // dest and result are don't care without a write
            if (exp_en) begin
                check_reg("wb_addr_o", wb_addr, pat_mem[idx*4+2][4:0]);
                check_word("wb_data_o", wb_data, pat_mem[idx*4+3]);
            end
            // auipc also against own pc model
            if (inst[6:0] == AUIPC) begin
                check_word("wb_data_o", wb_data,
                           word_t'(4 * accepted) + {inst[31:12], 12'b0});
            end
            @(posedge clk);
            accepted++;
        end
    endtask

    initial begin
        int stalls;
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        seed        = 32'h9de2;
        err_cnt     = 0;
        timeout_cnt = 0;
        accepted    = 0;
        $readmemh("tb/rv_core_patterns.txt", pat_mem);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // idle after reset, pc at reset value
        repeat (2) stall_cycle();

        for (int i = 0; i < NUM_PAT && timeout_cnt == 0; i++) begin
            stalls = {$random(seed)} % 4;
            repeat (stalls) stall_cycle();
            run_pattern(i);
        end

        // final pc after the last accept
        stall_cycle();

        $display("errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* verilog/rv_core.sv */
module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  word_t     inst_i,
    input  logic      inst_valid_i,
    output word_t     inst_addr_o,
    output logic      retire_o,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    word_t     pc;
    word_t     rdata1;
    word_t     rdata2;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     alu_result;
    logic      reg_we;

    // decode to execute bundle
    rv_dec_if dec_bus ();

    rv_fetch #(
        .RESET_PC (RESET_PC)
    ) i_rv_fetch (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .advance_i (inst_valid_i),
        .pc_o      (pc)
    );

    rv_decoder i_rv_decoder (
        .inst_i      (inst_i),
        .pc_i        (pc),
        .reg1_data_i (rdata1),
        .reg2_data_i (rdata2),
        .reg1_addr_o (raddr1),
        .reg2_addr_o (raddr2),
        .dec         (dec_bus.dec)
    );

    // write only on an accepted instruction
    assign reg_we = inst_valid_i & dec_bus.wd;

    rv_regfile i_rv_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .waddr_i  (dec_bus.wreg),
        .we_i     (reg_we),
        .wdata_i  (alu_result),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    rv_alu i_rv_alu (
        .dec      (dec_bus.exe),
        .result_o (alu_result)
    );

    // retire and write-back view
    assign inst_addr_o = pc;
    assign retire_o    = inst_valid_i;
    assign wb_en_o     = reg_we;
    assign wb_addr_o   = dec_bus.wreg;
    assign wb_data_o   = alu_result;

endmodule

/* verilog/rv_fetch.sv */
module rv_fetch import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  advance_i,
    output word_t pc_o
);

    word_t pc_q;

    // sequential fetch only, no branches
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (advance_i) begin
            // next word
            pc_q <= pc_q + 32'd4;
        end
    end

    // holds while imem not valid
    assign pc_o = pc_q;

endmodule

/* verilog/rv_alu.sv */
module rv_alu import rv_pkg::*; (
    rv_dec_if.exe dec,
    output word_t result_o
);

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;

    // operand 1 mux
    always_comb begin
        case (dec.src1_sel)
            PC:      op1 = dec.pc;
            ZERO:    op1 = '0;
            default: op1 = dec.reg1;
        endcase
    end

    // operand 2 mux
    always_comb begin
        case (dec.src2_sel)
            IMM:     op2 = dec.imm;
            default: op2 = dec.reg2;
        endcase
    end

    // shift amount from low five bits only
    assign shamt = op2[4:0];

    always_comb begin
        case (dec.aluop)
            ADD:     result_o = op1 + op2;
            SUB:     result_o = op1 - op2;
            SLL:     result_o = op1 << shamt;
            SLT:     result_o = {31'b0, $signed(op1) < $signed(op2)};
            SLTU:    result_o = {31'b0, op1 < op2};
            XOR:     result_o = op1 ^ op2;
            SRL:     result_o = op1 >> shamt;
            SRA:     result_o = word_t'($signed(op1) >>> shamt);
            OR:      result_o = op1 | op2;
            AND:     result_o = op1 & op2;
            default: result_o = '0;
        endcase
    end

endmodule

/* verilog/rv_regfile.sv */
module rv_regfile import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  reg_addr_t waddr_i,
    input  logic      we_i,
    input  word_t     wdata_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    // x1..x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, x0 reads zero
    // no bypass, a write shows up for the next instruction
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

/* verilog/rv_decoder.sv */
module rv_decoder import rv_pkg::*; (
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    rv_dec_if.dec     dec
);

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic        f7_zero;
    logic        f7_alt;

    // instruction fields
    assign opcode      = opcode_e'(inst_i[6:0]);
    assign funct3      = inst_i[14:12];
    assign funct7      = inst_i[31:25];
    assign reg1_addr_o = inst_i[19:15];
    assign reg2_addr_o = inst_i[24:20];

    // funct7 qualifiers, alt means bit 5 set and nothing else
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    // operands pass straight through
    assign dec.wreg = inst_i[11:7];
    assign dec.reg1 = reg1_data_i;
    assign dec.reg2 = reg2_data_i;
    assign dec.pc   = pc_i;

    rv_imm_gen i_rv_imm_gen (
        .inst_i (inst_i),
        .imm_o  (dec.imm)
    );

    always_comb begin
        // nop unless a legal encoding is found
        dec.wd       = 1'b0;
        dec.aluop    = ADD;
        dec.src1_sel = REG1;
        dec.src2_sel = REG2;
        case (opcode)
            OP: begin
                dec.src2_sel = REG2;
                case (funct3)
                    F3_ADD:  dec.aluop = f7_alt ? SUB : ADD;
                    F3_SLL:  dec.aluop = SLL;
                    F3_SLT:  dec.aluop = SLT;
                    F3_SLTU: dec.aluop = SLTU;
                    F3_XOR:  dec.aluop = XOR;
                    F3_SR:   dec.aluop = f7_alt ? SRA : SRL;
                    F3_OR:   dec.aluop = OR;
                    default: dec.aluop = AND;
                endcase
                // only add/sub and srl/sra have an alternate form
                if (f7_zero) begin
                    dec.wd = 1'b1;
                end else if (f7_alt && (funct3 == F3_ADD || funct3 == F3_SR)) begin
                    dec.wd = 1'b1;
                end
            end
            OP_IMM: begin
                dec.src2_sel = IMM;
                dec.wd       = 1'b1;
                case (funct3)
                    F3_ADD:  dec.aluop = ADD;
                    F3_SLT:  dec.aluop = SLT;
                    F3_SLTU: dec.aluop = SLTU;
                    F3_XOR:  dec.aluop = XOR;
                    F3_OR:   dec.aluop = OR;
                    F3_AND:  dec.aluop = AND;
                    F3_SLL: begin
                        dec.aluop = SLL;
                        dec.wd    = f7_zero;
                    end
                    default: begin
                        // srli / srai picked by imm bit 10
                        dec.aluop = f7_alt ? SRA : SRL;
                        dec.wd    = f7_zero | f7_alt;
                    end
                endcase
            end
            LUI: begin
                // 0 + u-imm
                dec.src1_sel = ZERO;
                dec.src2_sel = IMM;
                dec.wd       = 1'b1;
            end
            AUIPC: begin
                // pc + u-imm
                dec.src1_sel = PC;
                dec.src2_sel = IMM;
                dec.wd       = 1'b1;
            end
            default: begin
                dec.wd = 1'b0;
            end
        endcase
    end

endmodule

/* verilog/rv_imm_gen.sv */
module rv_imm_gen import rv_pkg::*; (
    input  word_t inst_i,
    output word_t imm_o
);

    opcode_e opcode;
    word_t   imm_i_type;
    word_t   imm_u_type;

    assign opcode = opcode_e'(inst_i[6:0]);

    // i-type: sign bit copied into the upper 20 bits
    // shift instructions only look at the low five bits later on
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};

    // u-type: upper 20 bits, low 12 cleared
    assign imm_u_type = {inst_i[31:12], 12'b0};

    always_comb begin
        case (opcode)
            LUI,
            AUIPC: begin
                imm_o = imm_u_type;
            end
            // OP_IMM and anything unknown
            default: begin
                imm_o = imm_i_type;
            end
        endcase
    end

endmodule

/* verilog/rv_dec_if.sv */
interface rv_dec_if import rv_pkg::*; ();

    // operation and operand routing
    alu_op_e   aluop;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;

    // write-back target
    logic      wd;
    reg_addr_t wreg;

    // operand values
    word_t     reg1;
    word_t     reg2;
    word_t     imm;
    word_t     pc;

    // decoder drives everything
    modport dec (output aluop, src1_sel, src2_sel, wd, wreg, reg1, reg2, imm, pc);

    // execute only needs the operation fields
    modport exe (input aluop, src1_sel, src2_sel, reg1, reg2, imm, pc);

endinterface

/* verilog/rv_pkg.sv */
package rv_pkg;

    // basic datapath types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_op_e;

    // first operand source
    typedef enum logic [1:0] {
        REG1 = 2'd0,
        PC   = 2'd1,
        ZERO = 2'd2
    } src1_sel_e;

    // second operand source
    typedef enum logic [1:0] {
        REG2 = 2'd0,
        IMM  = 2'd1
    } src2_sel_e;

    // funct3 codes shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage
